// ==== verilog/soc_ctrl_pkg.sv ====
`default_nettype none

package soc_ctrl_pkg;

	// Bus widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int SEL_W = 4;
	localparam int CSR_ADDR_W = 14;
	// Upper CSR address bits pick the peripheral
	localparam int CSR_BANK_W = 4;

	typedef logic [DATA_W-1:0] word_t;
	// Word address, taken from Wishbone bits 15..2
	typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

	// Slave slots on address bits 30..28, bit 31 is a shadow
	typedef enum logic [2:0] {
		SLOT_MONITOR = 3'd0,
		SLOT_CSR     = 3'd6
	} slot_e;

	// Bits 31..18 all zero means a null pointer access
	localparam int NULL_REGION_LSB = 18;

	// System controller bank, 0x60001000 on Wishbone
	localparam int SYSCTL_BANK = 1;

	typedef enum logic [CSR_ADDR_W-CSR_BANK_W-1:0] {
		REG_GPIO_IN       = 0,
		REG_GPIO_OUT      = 1,
		REG_TIMER_CTRL    = 2,
		REG_TIMER_COMPARE = 3,
		REG_TIMER_COUNTER = 4,
		REG_DEBUG_CTRL    = 5,
		REG_SYSTEM_ID     = 6,
		REG_HARD_RESET    = 7
	} sysctl_reg_e;

	localparam int GPIO_IN_W = 7;
	localparam int GPIO_OUT_W = 2;
	localparam word_t SYSTEM_ID = 32'h13004D31;

	// Flash leaves reset this many cycles after the request ends
	localparam int FLASH_RST_CYCLES = 128;

endpackage

`default_nettype wire

// ==== verilog/wb_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface wb_if;
	import soc_ctrl_pkg::*;

	logic [ADDR_W-1:0] adr;
	word_t dat_w;
	word_t dat_r;
	logic [SEL_W-1:0] sel;
	logic we;
	logic cyc;
	logic stb;
	logic ack;

	// Classic cycle, request held until ack
	modport master (output adr, dat_w, sel, we, cyc, stb, input dat_r, ack);
	modport slave (input adr, dat_w, sel, we, cyc, stb, output dat_r, ack);

endinterface

`default_nettype wire

// ==== verilog/csr_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface csr_if;
	import soc_ctrl_pkg::*;

	csr_addr_t csr_a;
	logic csr_we;
	word_t csr_dw;
	// Registered by the peripheral one cycle after csr_a
	word_t csr_dr;

	modport bridge (output csr_a, csr_we, csr_dw, input csr_dr);
	modport peripheral (input csr_a, csr_we, csr_dw, output csr_dr);

endinterface

`default_nettype wire

// ==== verilog/rst_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module rst_sequencer #(
	parameter int unsigned RST_HOLD_CYCLES = 1048575
) (
	input  logic sys_clk,
	input  logic trigger_reset,
	input  logic hard_reset_req_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);
	import soc_ctrl_pkg::*;

	localparam int HOLD_W = $clog2(RST_HOLD_CYCLES + 1);
	localparam int FLASH_W = $clog2(FLASH_RST_CYCLES + 1);

	logic [HOLD_W-1:0] hold_cnt;
	logic [FLASH_W-1:0] flash_cnt;
	logic rst_req;
	logic flash_done;

	// External button or software request
	assign rst_req = trigger_reset | hard_reset_req_i;
	assign flash_done = (flash_cnt == FLASH_W'(FLASH_RST_CYCLES));

	// --------------------------------------
	// System reset stretch
	always_ff @(posedge sys_clk) begin
		if (rst_req) begin
			hold_cnt <= HOLD_W'(RST_HOLD_CYCLES);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
		sys_rst_o <= (hold_cnt != '0);
	end

	// --------------------------------------
	// Flash comes out of reset first, so the boot memory is readable
	// by the time the system reset lets go
	always_ff @(posedge sys_clk) begin
		if (rst_req) begin
			flash_cnt <= '0;
		end else if (!flash_done) begin
			flash_cnt <= flash_cnt + 1'b1;
		end
	end

	assign flash_rst_n_o = flash_done;

endmodule

`default_nettype wire

// ==== verilog/wb_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_decoder (
	input  logic sys_clk,
	input  logic sys_rst_i,
	input  soc_ctrl_pkg::word_t adr_i,
	input  soc_ctrl_pkg::word_t dat_i,
	input  logic [soc_ctrl_pkg::SEL_W-1:0] sel_i,
	input  logic we_i,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic bus_errors_en_i,
	output soc_ctrl_pkg::word_t dat_o,
	output logic ack_o,
	output logic err_o,
	wb_if.master mon_o,
	wb_if.master csr_o
);
	import soc_ctrl_pkg::*;

	slot_e slot;
	logic null_q;

	// Bit 31 ignored
	assign slot = slot_e'(adr_i[ADDR_W-2 -: $bits(slot_e)]);

	// Request fields go to both slaves, only cyc is steered
	assign mon_o.adr = adr_i;
	assign mon_o.dat_w = dat_i;
	assign mon_o.sel = sel_i;
	assign mon_o.we = we_i;
	assign mon_o.stb = stb_i;
	assign mon_o.cyc = cyc_i & (slot == SLOT_MONITOR);

	assign csr_o.adr = adr_i;
	assign csr_o.dat_w = dat_i;
	assign csr_o.sel = sel_i;
	assign csr_o.we = we_i;
	assign csr_o.stb = stb_i;
	assign csr_o.cyc = cyc_i & (slot == SLOT_CSR);

	// Response mux
	always_comb begin
		case (slot)
			SLOT_MONITOR: begin
				dat_o = mon_o.dat_r;
				ack_o = mon_o.ack;
			end
			SLOT_CSR: begin
				dat_o = csr_o.dat_r;
				ack_o = csr_o.ack;
			end
			// Unmapped, the master waits forever
			default: begin
				dat_o = '0;
				ack_o = 1'b0;
			end
		endcase
	end

	// --------------------------------------
	// Null pointer catch
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			null_q <= 1'b0;
		end else begin
			null_q <= (adr_i[ADDR_W-1:NULL_REGION_LSB] == '0);
		end
	end

	// Err rides along with ack rather than replacing it
	assign err_o = bus_errors_en_i & null_q & ack_o;

endmodule

`default_nettype wire

// ==== verilog/monitor_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module monitor_ram #(
	parameter int unsigned MON_WORDS = 256
) (
	input  logic sys_clk,
	input  logic sys_rst_i,
	input  logic write_lock_i,
	wb_if.slave bus
);
	import soc_ctrl_pkg::*;

	localparam int IDX_W = $clog2(MON_WORDS);

	word_t mem [MON_WORDS];
	word_t rd_q;
	logic ack_q;
	logic [IDX_W-1:0] idx;
	logic access;

	// Low word-address bits only, so the RAM repeats through its slot
	assign idx = bus.adr[IDX_W+1:2];
	// New access only when no ack is out
	assign access = bus.cyc & bus.stb & ~ack_q;

	// One ack per access
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// --------------------------------------
	// Storage
	always_ff @(posedge sys_clk) begin
		rd_q <= mem[idx];
		// Locked writes still get their ack
		if (access && bus.we && !write_lock_i) begin
			for (int i = 0; i < SEL_W; i++) begin
				if (bus.sel[i]) begin
					mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
				end
			end
		end
	end

	assign bus.ack = ack_q;
	assign bus.dat_r = rd_q;

endmodule

`default_nettype wire

// ==== verilog/csr_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_bridge (
	input  logic sys_clk,
	input  logic sys_rst_i,
	wb_if.slave bus,
	csr_if.bridge csr
);
	import soc_ctrl_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT,
		S_READ,
		S_ACK
	} state_e;

	state_e state;
	logic we_q;
	logic ack_q;
	csr_addr_t adr_q;
	word_t dw_q;
	word_t dr_q;

	// --------------------------------------
	// Sequencer, ack three cycles after stb
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= S_IDLE;
			we_q <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			// Both are single-cycle pulses
			we_q <= 1'b0;
			ack_q <= 1'b0;
			case (state)
				S_IDLE: begin
					if (bus.cyc && bus.stb) begin
						we_q <= bus.we;
						state <= S_WAIT;
					end
				end
				// Peripheral registers its read word here
				S_WAIT: state <= S_READ;
				S_READ: begin
					ack_q <= 1'b1;
					state <= S_ACK;
				end
				// Master drops stb on this edge
				default: state <= S_IDLE;
			endcase
		end
	end

	// Address, write data and read capture
	always_ff @(posedge sys_clk) begin
		if (state == S_IDLE && bus.cyc && bus.stb) begin
			adr_q <= bus.adr[CSR_ADDR_W+1:2];
			dw_q <= bus.dat_w;
		end
		if (state == S_READ) begin
			dr_q <= csr.csr_dr;
		end
	end

	assign csr.csr_a = adr_q;
	assign csr.csr_we = we_q;
	assign csr.csr_dw = dw_q;
	assign bus.ack = ack_q;
	assign bus.dat_r = dr_q;

endmodule

`default_nettype wire

// ==== verilog/sysctl.sv ====
`timescale 1ns/100ps
`default_nettype none

module sysctl (
	input  logic sys_clk,
	input  logic sys_rst_i,
	input  logic [soc_ctrl_pkg::GPIO_IN_W-1:0] gpio_i,
	csr_if.peripheral csr,
	output logic [soc_ctrl_pkg::GPIO_OUT_W-1:0] led_o,
	output logic gpio_irq_o,
	output logic timer0_irq_o,
	output logic debug_write_lock_o,
	output logic bus_errors_en_o,
	output logic hard_reset_req_o
);
	import soc_ctrl_pkg::*;

	logic csr_sel;
	logic csr_wr;
	sysctl_reg_e reg_idx;
	logic [GPIO_IN_W-1:0] gpio_s1;
	logic [GPIO_IN_W-1:0] gpio_s2;
	logic [GPIO_IN_W-1:0] gpio_prev;
	logic timer_en;
	logic timer_ar;
	word_t timer_compare;
	word_t timer_counter;
	word_t dr_q;

	// Bank decode
	assign csr_sel = (csr.csr_a[CSR_ADDR_W-1 -: CSR_BANK_W] == CSR_BANK_W'(SYSCTL_BANK));
	assign reg_idx = sysctl_reg_e'(csr.csr_a[CSR_ADDR_W-CSR_BANK_W-1:0]);
	assign csr_wr = csr_sel & csr.csr_we;

	// --------------------------------------
	// GPIO input sync, then edge compare
	always_ff @(posedge sys_clk) begin
		gpio_s1 <= gpio_i;
		gpio_s2 <= gpio_s1;
		gpio_prev <= gpio_s2;
	end

	// Any input bit changed
	assign gpio_irq_o = |(gpio_s2 ^ gpio_prev);

	// --------------------------------------
	// Timer
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			timer_en <= 1'b0;
			timer_ar <= 1'b0;
			timer_compare <= '0;
			timer_counter <= '0;
			timer0_irq_o <= 1'b0;
		end else begin
			timer0_irq_o <= 1'b0;
			if (timer_en) begin
				if (timer_counter == timer_compare) begin
					timer_counter <= '0;
					timer0_irq_o <= 1'b1;
					// One-shot unless autorestart
					if (!timer_ar) begin
						timer_en <= 1'b0;
					end
				end else begin
					timer_counter <= timer_counter + 1'b1;
				end
			end
			// Software write wins over the count
			if (csr_wr) begin
				case (reg_idx)
					REG_TIMER_CTRL: begin
						timer_en <= csr.csr_dw[0];
						timer_ar <= csr.csr_dw[1];
					end
					REG_TIMER_COMPARE: timer_compare <= csr.csr_dw;
					REG_TIMER_COUNTER: timer_counter <= csr.csr_dw;
					default: ;
				endcase
			end
		end
	end

	// --------------------------------------
	// LEDs, debug bits, hard reset pulse
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			led_o <= '0;
			debug_write_lock_o <= 1'b0;
			bus_errors_en_o <= 1'b0;
			hard_reset_req_o <= 1'b0;
		end else begin
			// Any value written triggers it
			hard_reset_req_o <= csr_wr && (reg_idx == REG_HARD_RESET);
			if (csr_wr && reg_idx == REG_GPIO_OUT) begin
				led_o <= csr.csr_dw[GPIO_OUT_W-1:0];
			end
			if (csr_wr && reg_idx == REG_DEBUG_CTRL) begin
				debug_write_lock_o <= csr.csr_dw[0];
				bus_errors_en_o <= csr.csr_dw[1];
			end
		end
	end

	// Read back, zero outside the bank so it can be ORed later
	always_ff @(posedge sys_clk) begin
		dr_q <= '0;
		if (csr_sel) begin
			case (reg_idx)
				REG_GPIO_IN: dr_q <= word_t'(gpio_s2);
				REG_GPIO_OUT: dr_q <= word_t'(led_o);
				REG_TIMER_CTRL: dr_q <= word_t'({timer_ar, timer_en});
				REG_TIMER_COMPARE: dr_q <= timer_compare;
				REG_TIMER_COUNTER: dr_q <= timer_counter;
				REG_DEBUG_CTRL: dr_q <= word_t'({bus_errors_en_o, debug_write_lock_o});
				REG_SYSTEM_ID: dr_q <= SYSTEM_ID;
				default: dr_q <= '0;
			endcase
		end
	end

	assign csr.csr_dr = dr_q;

endmodule

`default_nettype wire

// ==== verilog/soc_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_ctrl #(
	parameter int unsigned RST_HOLD_CYCLES = 1048575,
	parameter int unsigned MON_WORDS = 256
) (
	input  logic sys_clk,
	input  logic trigger_reset,
	// Wishbone slave
	input  logic [soc_ctrl_pkg::ADDR_W-1:0] wb_adr_i,
	input  soc_ctrl_pkg::word_t wb_dat_i,
	output soc_ctrl_pkg::word_t wb_dat_o,
	input  logic [soc_ctrl_pkg::SEL_W-1:0] wb_sel_i,
	input  logic wb_we_i,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	output logic wb_ack_o,
	output logic wb_err_o,
	// GPIO and interrupts
	input  logic [soc_ctrl_pkg::GPIO_IN_W-1:0] gpio_i,
	output logic [soc_ctrl_pkg::GPIO_OUT_W-1:0] led_o,
	output logic gpio_irq_o,
	output logic timer0_irq_o,
	// Resets
	output logic sys_rst_o,
	flash_rst_n_o
);

	logic debug_write_lock;
	logic bus_errors_en;
	logic hard_reset_req;

	wb_if mon_bus ();
	wb_if csr_bus ();
	csr_if csr ();

	// --------------------------------------
	// Reset generation
	rst_sequencer #(
		.RST_HOLD_CYCLES(RST_HOLD_CYCLES)
	) rst_sequencer0 (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.hard_reset_req_i(hard_reset_req),
		.sys_rst_o(sys_rst_o),
		.flash_rst_n_o(flash_rst_n_o)
	);

	// --------------------------------------
	// Bus switch, monitor at 0x0, CSR at 0x6
	wb_decoder wb_decoder0 (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.adr_i(wb_adr_i),
		.dat_i(wb_dat_i),
		.sel_i(wb_sel_i),
		.we_i(wb_we_i),
		.cyc_i(wb_cyc_i),
		.stb_i(wb_stb_i),
		.bus_errors_en_i(bus_errors_en),
		.dat_o(wb_dat_o),
		.ack_o(wb_ack_o),
		.err_o(wb_err_o),
		.mon_o(mon_bus.master),
		.csr_o(csr_bus.master)
	);

	// Takes the slot of the boot flash
	monitor_ram #(
		.MON_WORDS(MON_WORDS)
	) monitor_ram0 (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.write_lock_i(debug_write_lock),
		.bus(mon_bus.slave)
	);

	csr_bridge csr_bridge0 (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.bus(csr_bus.slave),
		.csr(csr.bridge)
	);

	// --------------------------------------
	// Only CSR peripheral, so no read OR
	sysctl sysctl0 (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.gpio_i(gpio_i),
		.csr(csr.peripheral),
		.led_o(led_o),
		.gpio_irq_o(gpio_irq_o),
		.timer0_irq_o(timer0_irq_o),
		.debug_write_lock_o(debug_write_lock),
		.bus_errors_en_o(bus_errors_en),
		.hard_reset_req_o(hard_reset_req)
	);

endmodule

`default_nettype wire

// ==== tb/soc_ctrl_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_ctrl_tb;

	localparam int RST_HOLD = 200;
	localparam int ACK_WAIT = 50;
	// System controller bank on Wishbone
	localparam logic [31:0] SYSCTL_BASE = 32'h6000_1000;
	localparam logic [31:0] SYSTEM_ID_WORD = 32'h1300_4D31;
	localparam int IDX_GPIO_IN = 0;
	localparam int IDX_GPIO_OUT = 1;
	localparam int IDX_TIMER_CTRL = 2;
	localparam int IDX_TIMER_COMPARE = 3;
	localparam int IDX_TIMER_COUNTER = 4;
	localparam int IDX_DEBUG_CTRL = 5;
	localparam int IDX_SYSTEM_ID = 6;
	localparam int IDX_HARD_RESET = 7;

	typedef enum {OP_WRITE, OP_READ, OP_GPIO, OP_TIMER, OP_RESET, OP_LED} op_e;

	typedef struct {
		op_e op;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0] sel;
		logic [31:0] exp;
		logic exp_err;
	} entry_t;

	logic sys_clk;
	logic trigger_reset;
	logic [31:0] wb_adr_i;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic [3:0] wb_sel_i;
	logic wb_we_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_ack_o;
	logic wb_err_o;
	logic [6:0] gpio_i;
	logic [1:0] led_o;
	logic gpio_irq_o;
	logic timer0_irq_o;
	logic sys_rst_o;
	logic flash_rst_n_o;

	integer seed;
	int error_count;
	int cycles;
	int timeout_limit;
	entry_t stim_q[$];

	soc_ctrl #(
		.RST_HOLD_CYCLES(RST_HOLD)
	) dut0 (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_sel_i(wb_sel_i),
		.wb_we_i(wb_we_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_ack_o(wb_ack_o),
		.wb_err_o(wb_err_o),
		.gpio_i(gpio_i),
		.led_o(led_o),
		.gpio_irq_o(gpio_irq_o),
		.timer0_irq_o(timer0_irq_o),
		.sys_rst_o(sys_rst_o),
		.flash_rst_n_o(flash_rst_n_o)
	);

	// 20 ns clock
	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// Watchdog
	initial begin
		cycles = 0;
		forever begin
			@(posedge sys_clk);
			cycles++;
			if (cycles > timeout_limit) begin
				report_failure("simulation ran past its cycle limit");
			end
		end
	end

	// ----------------------------------------
	// Checking and failure reporting
	task automatic stop_on_error();
		$display("Errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_failure(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		error_count++;
		stop_on_error();
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			error_count++;
			stop_on_error();
		end
	endtask

	// ----------------------------------------
	// One classic Wishbone cycle, stb held until ack
	task automatic bus_access(input logic we, input logic [31:0] adr,
			input logic [31:0] dat, input logic [3:0] sel,
			output logic [31:0] rdata, output logic err);
		int n;
		n = 0;
		@(posedge sys_clk);
		wb_adr_i <= adr;
		wb_dat_i <= dat;
		wb_sel_i <= sel;
		wb_we_i <= we;
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		do begin
			@(negedge sys_clk);
			n++;
			if (n > ACK_WAIT) begin
				report_failure($sformatf("no ack within %0d cycles at %h", ACK_WAIT, adr));
			end
		end while (wb_ack_o !== 1'b1);
		rdata = wb_dat_o;
		err = wb_err_o;
		@(posedge sys_clk);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i <= 1'b0;
	endtask

	// Reset must rise, flash must leave reset first, then reset falls
	task automatic wait_reset_cycle();
		int n;
		logic flash_low;
		logic flash_rise;
		n = 0;
		flash_low = 1'b0;
		flash_rise = 1'b0;
		while (sys_rst_o !== 1'b1) begin
			@(negedge sys_clk);
			n++;
			if (n > 10) begin
				report_failure("sys_rst_o never went high");
			end
		end
		n = 0;
		while (sys_rst_o !== 1'b0) begin
			@(negedge sys_clk);
			n++;
			if (n > RST_HOLD + 50) begin
				report_failure("sys_rst_o never released");
			end
			if (sys_rst_o === 1'b1) begin
				check_value("ack during reset", 32'(wb_ack_o), 32'd0);
				if (flash_rst_n_o === 1'b0) begin
					flash_low = 1'b1;
				end else if (flash_low && flash_rst_n_o === 1'b1) begin
					flash_rise = 1'b1;
				end
			end
		end
		check_value("flash released before system reset", 32'(flash_rise), 32'd1);
	endtask

	// ----------------------------------------
	// Stimulus table
	function automatic logic [31:0] sysctl_addr(input int idx);
		return SYSCTL_BASE + 32'(idx * 4);
	endfunction

	function automatic void add_entry(input op_e op, input logic [31:0] adr,
			input logic [31:0] dat, input logic [3:0] sel,
			input logic [31:0] exp, input logic exp_err);
		entry_t e;
		e.op = op;
		e.adr = adr;
		e.dat = dat;
		e.sel = sel;
		e.exp = exp;
		e.exp_err = exp_err;
		stim_q.push_back(e);
	endfunction

	task automatic build_stimulus();
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] merged;
		logic [31:0] c;
		// Random words, write then read back
		for (int i = 0; i < 6; i++) begin
			w = $random(seed);
			add_entry(OP_WRITE, 32'h40 + 32'(4 * i), w, 4'hf, 32'h0, 1'b0);
			add_entry(OP_READ, 32'h40 + 32'(4 * i), 32'h0, 4'hf, w, 1'b0);
		end
		// Bytes 0 and 2 only
		a = $random(seed);
		b = $random(seed);
		merged = {a[31:24], b[23:16], a[15:8], b[7:0]};
		add_entry(OP_WRITE, 32'h200, a, 4'hf, 32'h0, 1'b0);
		add_entry(OP_WRITE, 32'h200, b, 4'b0101, 32'h0, 1'b0);
		add_entry(OP_READ, 32'h200, 32'h0, 4'hf, merged, 1'b0);
		// Mirror above the RAM size
		add_entry(OP_READ, 32'h0004_0200, 32'h0, 4'hf, merged, 1'b0);
		// Locked write is dropped
		c = $random(seed);
		add_entry(OP_WRITE, sysctl_addr(IDX_DEBUG_CTRL), 32'h1, 4'hf, 32'h0, 1'b0);
		add_entry(OP_READ, sysctl_addr(IDX_DEBUG_CTRL), 32'h0, 4'hf, 32'h1, 1'b0);
		add_entry(OP_WRITE, 32'h200, c, 4'hf, 32'h0, 1'b0);
		add_entry(OP_READ, 32'h200, 32'h0, 4'hf, merged, 1'b0);
		add_entry(OP_WRITE, sysctl_addr(IDX_DEBUG_CTRL), 32'h0, 4'hf, 32'h0, 1'b0);
		add_entry(OP_WRITE, 32'h200, c, 4'hf, 32'h0, 1'b0);
		add_entry(OP_READ, 32'h200, 32'h0, 4'hf, c, 1'b0);
		// Null region errors, off then on
		w = $random(seed);
		add_entry(OP_WRITE, 32'h10, w, 4'hf, 32'h0, 1'b0);
		add_entry(OP_READ, 32'h10, 32'h0, 4'hf, w, 1'b0);
		add_entry(OP_WRITE, sysctl_addr(IDX_DEBUG_CTRL), 32'h2, 4'hf, 32'h0, 1'b0);
		add_entry(OP_READ, 32'h10, 32'h0, 4'hf, w, 1'b1);
		add_entry(OP_READ, 32'h0004_0010, 32'h0, 4'hf, w, 1'b0);
		add_entry(OP_WRITE, sysctl_addr(IDX_DEBUG_CTRL), 32'h0, 4'hf, 32'h0, 1'b0);
		// System controller basics
		add_entry(OP_READ, sysctl_addr(IDX_SYSTEM_ID), 32'h0, 4'hf, SYSTEM_ID_WORD, 1'b0);
		add_entry(OP_WRITE, sysctl_addr(IDX_GPIO_OUT), 32'h2, 4'hf, 32'h0, 1'b0);
		add_entry(OP_LED, 32'h0, 32'h0, 4'h0, 32'h2, 1'b0);
		add_entry(OP_READ, sysctl_addr(IDX_GPIO_OUT), 32'h0, 4'hf, 32'h2, 1'b0);
		add_entry(OP_READ, sysctl_addr(IDX_GPIO_IN), 32'h0, 4'hf, 32'h15, 1'b0);
		add_entry(OP_GPIO, 32'h0, 32'h2a, 4'h0, 32'h0, 1'b0);
		add_entry(OP_READ, sysctl_addr(IDX_GPIO_IN), 32'h0, 4'hf, 32'h2a, 1'b0);
		// One-shot timer, compare 40
		add_entry(OP_WRITE, sysctl_addr(IDX_TIMER_COMPARE), 32'd40, 4'hf, 32'h0, 1'b0);
		add_entry(OP_WRITE, sysctl_addr(IDX_TIMER_COUNTER), 32'd0, 4'hf, 32'h0, 1'b0);
		add_entry(OP_WRITE, sysctl_addr(IDX_TIMER_CTRL), 32'h1, 4'hf, 32'h0, 1'b0);
		add_entry(OP_TIMER, 32'h0, 32'd100, 4'h0, 32'h0, 1'b0);
		add_entry(OP_READ, sysctl_addr(IDX_TIMER_CTRL), 32'h0, 4'hf, 32'h0, 1'b0);
		add_entry(OP_READ, sysctl_addr(IDX_TIMER_COUNTER), 32'h0, 4'hf, 32'h0, 1'b0);
		// Software reset clears the LEDs
		add_entry(OP_WRITE, sysctl_addr(IDX_HARD_RESET), 32'ha5, 4'hf, 32'h0, 1'b0);
		add_entry(OP_RESET, 32'h0, 32'h0, 4'h0, 32'h0, 1'b0);
		add_entry(OP_READ, sysctl_addr(IDX_GPIO_OUT), 32'h0, 4'hf, 32'h0, 1'b0);
		add_entry(OP_LED, 32'h0, 32'h0, 4'h0, 32'h0, 1'b0);
		add_entry(OP_READ, sysctl_addr(IDX_DEBUG_CTRL), 32'h0, 4'hf, 32'h0, 1'b0);
	endtask

	// ----------------------------------------
	// Apply one table entry
	task automatic run_entry(input int idx);
		entry_t e;
		logic [31:0] rdata;
		logic err;
		int n;
		int hits;
		int at_cycle;
		e = stim_q[idx];
		case (e.op)
			OP_WRITE: begin
				bus_access(1'b1, e.adr, e.dat, e.sel, rdata, err);
				check_value($sformatf("entry %0d write err", idx), 32'(err), 32'(e.exp_err));
			end
			OP_READ: begin
				bus_access(1'b0, e.adr, 32'h0, e.sel, rdata, err);
				check_value($sformatf("entry %0d read data", idx), rdata, e.exp);
				check_value($sformatf("entry %0d read err", idx), 32'(err), 32'(e.exp_err));
			end
			OP_GPIO: begin
				hits = 0;
				at_cycle = 0;
				@(posedge sys_clk);
				gpio_i <= e.dat[6:0];
				// Two sync flops, then the compare
				for (n = 1; n <= 4; n++) begin
					@(negedge sys_clk);
					if (gpio_irq_o === 1'b1) begin
						hits++;
						at_cycle = n;
					end
				end
				check_value("gpio irq pulse count", 32'(hits), 32'd1);
				check_value("gpio irq delay", 32'(at_cycle), 32'd3);
			end
			OP_TIMER: begin
				n = 0;
				while (timer0_irq_o !== 1'b1) begin
					@(negedge sys_clk);
					n++;
					if (n > int'(e.dat)) begin
						report_failure("timer interrupt never fired");
					end
				end
				@(negedge sys_clk);
				check_value("timer irq width", 32'(timer0_irq_o), 32'd0);
			end
			OP_RESET: wait_reset_cycle();
			default: begin
				@(negedge sys_clk);
				check_value($sformatf("entry %0d led_o", idx), 32'(led_o), e.exp);
			end
		endcase
	endtask

	// ----------------------------------------
	// Main sequence
	initial begin
		seed = 1590;
		error_count = 0;
		trigger_reset = 1'b1;
		// RAM read pending from the start, no ack allowed while in reset
		wb_adr_i = 32'h40;
		wb_dat_i = '0;
		wb_sel_i = 4'hf;
		wb_we_i = 1'b0;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		gpio_i = 7'h15;
		build_stimulus();
		// Two reset stretches plus the table
		timeout_limit = 2 * RST_HOLD + 20 * stim_q.size() + 1000;
		repeat (3) @(posedge sys_clk);
		trigger_reset <= 1'b0;
		fork
			wait_reset_cycle();
			begin
				// Request withdrawn well before reset lets go
				repeat (RST_HOLD / 2) @(posedge sys_clk);
				wb_cyc_i <= 1'b0;
				wb_stb_i <= 1'b0;
			end
		join
		foreach (stim_q[i]) begin
			run_entry(i);
		end
		repeat (2) @(posedge sys_clk);
		if (error_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			stop_on_error();
		end
	end

endmodule

`default_nettype wire

// ==== soc_ctrl.f ====
verilog/soc_ctrl_pkg.sv
verilog/wb_if.sv
verilog/csr_if.sv
verilog/rst_sequencer.sv
verilog/wb_decoder.sv
verilog/monitor_ram.sv
verilog/csr_bridge.sv
verilog/sysctl.sv
verilog/soc_ctrl.sv
tb/soc_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module soc_ctrl_tb \
	-f soc_ctrl.f -o soc_ctrl_sim

out=$(./obj_dir/soc_ctrl_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "No errors"; then
	exit 0
fi
exit 1
